/* design/lc4_alu.sv */
// Execute-stage datapath of the LC4 pipeline
// Arithmetic and logic, base plus offset, CONST and the branch target PC+1+offset
// Also tests the branch mask against the current condition codes
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
   input  wire lc4_pkg::alu_op_t i_op,
   input  wire lc4_pkg::word_t   i_pc,
   input  wire lc4_pkg::word_t   i_a,        // rs after bypass
   input  wire lc4_pkg::word_t   i_b,        // rt after bypass
   input  wire lc4_pkg::word_t   i_imm,
   input  wire lc4_pkg::nzp_t    i_br_nzp,
   input  wire lc4_pkg::nzp_t    i_nzp,      // Current NZP register
   output lc4_pkg::word_t        o_result,
   output logic                  o_br_taken
);
   import lc4_pkg::*;

   word_t pc_plus_one;

   assign pc_plus_one = i_pc + 16'd1;

   always_comb begin
      case (i_op)
         ALU_ADD:  o_result = i_a + i_b;
         ALU_SUB:  o_result = i_a - i_b;
         ALU_AND:  o_result = i_a & i_b;
         ALU_OR:   o_result = i_a | i_b;
         ALU_XOR:  o_result = i_a ^ i_b;
         ALU_PASS: o_result = i_imm;                  // CONST
         ALU_BR:   o_result = pc_plus_one + i_imm;    // Branch target
         default:  o_result = i_a + i_imm;            // LDR, STR address and ADD imm5
      endcase
   end

   // Mask of 000 can never match, so NOP branches stay not-taken
   assign o_br_taken = (i_op == ALU_BR) && (|(i_br_nzp & i_nzp));

endmodule

`default_nettype wire

/* design/lc4_decoder.sv */
// Combinational LC4 decoder for the decode stage
// Produces register selects, enables, ALU op and the sign-extended immediate
// Anything outside the supported subset leaves all enables low and runs as a NOP
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::ctl_t       o_ctl
);
   import lc4_pkg::*;

   logic [2:0] sub_op;
   word_t      imm5_sx, imm6_sx, imm9_sx;

   assign sub_op  = i_insn[5:3];
   assign imm5_sx = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6_sx = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9_sx = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      o_ctl    = '0;
      o_ctl.rd = i_insn[11:9];
      o_ctl.rs = i_insn[8:6];
      o_ctl.rt = i_insn[2:0];
      case (i_insn[15:12])
         OP_BR: begin
            o_ctl.br_nzp    = i_insn[11:9];
            o_ctl.is_branch = |i_insn[11:9];   // nzp 000 never branches
            o_ctl.alu_op    = ALU_BR;
            o_ctl.imm       = imm9_sx;
         end
         OP_ARITH: begin
            if (i_insn[5]) begin                // ADD imm5 goes through the address adder
               o_ctl.rs_re      = 1'b1;
               o_ctl.regfile_we = 1'b1;
               o_ctl.alu_op     = ALU_ADDR;
               o_ctl.imm        = imm5_sx;
            end else if (sub_op == SUB_ADD || sub_op == SUB_SUB) begin
               o_ctl.rs_re      = 1'b1;
               o_ctl.rt_re      = 1'b1;
               o_ctl.regfile_we = 1'b1;
               o_ctl.alu_op     = (sub_op == SUB_SUB) ? ALU_SUB : ALU_ADD;
            end
         end
         OP_LOGIC: begin
            if (sub_op == SUB_AND || sub_op == SUB_OR || sub_op == SUB_XOR) begin
               o_ctl.rs_re      = 1'b1;
               o_ctl.rt_re      = 1'b1;
               o_ctl.regfile_we = 1'b1;
               o_ctl.alu_op     = (sub_op == SUB_AND) ? ALU_AND :
                                  (sub_op == SUB_OR)  ? ALU_OR  : ALU_XOR;
            end
         end
         OP_LDR: begin
            o_ctl.rs_re      = 1'b1;            // Base register
            o_ctl.regfile_we = 1'b1;
            o_ctl.is_load    = 1'b1;
            o_ctl.alu_op     = ALU_ADDR;
            o_ctl.imm        = imm6_sx;
         end
         OP_STR: begin
            o_ctl.rt       = i_insn[11:9];     // Store data sits where rd would be
            o_ctl.rs_re    = 1'b1;
            o_ctl.rt_re    = 1'b1;
            o_ctl.is_store = 1'b1;
            o_ctl.alu_op   = ALU_ADDR;
            o_ctl.imm      = imm6_sx;
         end
         OP_CONST: begin
            o_ctl.regfile_we = 1'b1;
            o_ctl.alu_op     = ALU_PASS;
            o_ctl.imm        = imm9_sx;
         end
         default: ;                             // Unsupported, stays a NOP
      endcase
      o_ctl.nzp_we = o_ctl.regfile_we;         // Every register writer sets the codes
   end

endmodule

`default_nettype wire

/* design/lc4_hazard_ctrl.sv */
// Hazard control for the LC4 pipeline
// Load-use and branch-behind-NZP-writer stalls, flush on a taken branch,
// and the bypass selects for both ALU operands and the store data
// A flush masks the stall since the stalled instruction is on the wrong path
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_ctrl (
   input  wire lc4_pkg::ctl_t i_d_ctl,
   input  wire lc4_pkg::ctl_t i_x_ctl,
   input  wire lc4_pkg::ctl_t i_m_ctl,
   input  wire lc4_pkg::ctl_t i_w_ctl,
   input  wire                i_br_taken,
   output logic               o_stall,
   output logic               o_flush,
   output lc4_pkg::byp_sel_t  o_a_sel,
   output lc4_pkg::byp_sel_t  o_b_sel,
   output logic               o_st_sel    // 1 picks the W load value
);
   import lc4_pkg::*;

   logic load_use, br_wait;

   // Store data from a load is fixed up later by the WM bypass, so no stall there
   assign load_use = i_x_ctl.is_load && i_x_ctl.regfile_we &&
                     ((i_d_ctl.rs_re && i_d_ctl.rs == i_x_ctl.rd) ||
                      (i_d_ctl.rt_re && !i_d_ctl.is_store && i_d_ctl.rt == i_x_ctl.rd));

   // Hold the branch until the codes writer is in W, it enters X after the NZP update
   assign br_wait = i_d_ctl.is_branch && (i_x_ctl.nzp_we || i_m_ctl.nzp_we);

   assign o_flush = i_br_taken;
   assign o_stall = (load_use || br_wait) && !i_br_taken;

   // Youngest producer wins, M before W
   always_comb begin
      o_a_sel = BYP_REG;
      if (i_x_ctl.rs_re && i_m_ctl.regfile_we && i_m_ctl.rd == i_x_ctl.rs)
         o_a_sel = BYP_M;
      else if (i_x_ctl.rs_re && i_w_ctl.regfile_we && i_w_ctl.rd == i_x_ctl.rs)
         o_a_sel = BYP_W;

      o_b_sel = BYP_REG;
      if (i_x_ctl.rt_re && i_m_ctl.regfile_we && i_m_ctl.rd == i_x_ctl.rt)
         o_b_sel = BYP_M;
      else if (i_x_ctl.rt_re && i_w_ctl.regfile_we && i_w_ctl.rd == i_x_ctl.rt)
         o_b_sel = BYP_W;
   end

   // WM bypass, load in W feeding a store's data in M
   assign o_st_sel = i_m_ctl.is_store && i_w_ctl.is_load && i_w_ctl.regfile_we &&
                     (i_w_ctl.rd == i_m_ctl.rt);

endmodule

`default_nettype wire

/* design/lc4_pipeline.sv */
// Top level of the five-stage LC4 pipeline, fetch to writeback
// Instruction and data memories are outside and read combinationally
// o_wb_* shows each register write as it retires, in program order
`timescale 1ns/1ps
`default_nettype none

module lc4_pipeline (
   input  wire                    gwe,
   input  wire                    i_rst_n,
   output lc4_pkg::word_t         o_cur_pc,
   input  wire lc4_pkg::word_t    i_cur_insn,     // Instruction at o_cur_pc
   output lc4_pkg::word_t         o_dmem_addr,    // Zero unless load or store in M
   input  wire lc4_pkg::word_t    i_dmem_data,
   output logic                   o_dmem_we,
   output lc4_pkg::word_t         o_dmem_towrite,
   output logic                   o_wb_we,
   output lc4_pkg::reg_sel_t      o_wb_sel,
   output lc4_pkg::word_t         o_wb_data
);
   import lc4_pkg::*;

   word_t    pc_q;
   d_stage_t d_in, d_q;
   x_stage_t x_in, x_q;
   m_stage_t m_in, m_q;
   w_stage_t w_in, w_q;
   ctl_t     dec_ctl;
   word_t    rs_data, rt_data, a_val, b_val, alu_result, wb_data;
   nzp_t     nzp_q, wb_nzp;
   logic     stall, flush, br_taken, st_sel;
   byp_sel_t a_sel, b_sel;

   // Fetch, predict not-taken
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n)   pc_q <= PC_RESET;
      else if (flush) pc_q <= alu_result;      // Redirect to branch target
      else if (!stall) pc_q <= pc_q + 16'd1;
   end
   assign o_cur_pc = pc_q;

   assign d_in = '{pc: pc_q, insn: i_cur_insn};
   lc4_stage_reg #(.payload_t(d_stage_t)) u_d_reg (.gwe(gwe), .i_rst_n(i_rst_n),
      .i_hold(stall), .i_clear(flush), .i_d(d_in), .o_q(d_q));

   // Decode and register read
   lc4_decoder u_dec (.i_insn(d_q.insn), .o_ctl(dec_ctl));
   lc4_regfile u_rf (.gwe(gwe), .i_rst_n(i_rst_n), .i_rs(dec_ctl.rs), .i_rt(dec_ctl.rt),
      .i_rd(w_q.ctl.rd), .i_we(w_q.ctl.regfile_we), .i_wdata(wb_data),
      .o_rs_data(rs_data), .o_rt_data(rt_data));

   assign x_in = '{ctl: dec_ctl, pc: d_q.pc, rs_data: rs_data, rt_data: rt_data};
   lc4_stage_reg #(.payload_t(x_stage_t)) u_x_reg (.gwe(gwe), .i_rst_n(i_rst_n),
      .i_hold(1'b0), .i_clear(stall || flush), .i_d(x_in), .o_q(x_q));   // Bubble on stall

   lc4_hazard_ctrl u_haz (.i_d_ctl(dec_ctl), .i_x_ctl(x_q.ctl), .i_m_ctl(m_q.ctl),
      .i_w_ctl(w_q.ctl), .i_br_taken(br_taken), .o_stall(stall), .o_flush(flush),
      .o_a_sel(a_sel), .o_b_sel(b_sel), .o_st_sel(st_sel));

   // Execute with MX and WX bypass
   assign a_val = (a_sel == BYP_M) ? m_q.result : (a_sel == BYP_W) ? wb_data : x_q.rs_data;
   assign b_val = (b_sel == BYP_M) ? m_q.result : (b_sel == BYP_W) ? wb_data : x_q.rt_data;

   // Branch reaches execute only after its codes writer has retired
   lc4_alu u_alu (.i_op(x_q.ctl.alu_op), .i_pc(x_q.pc), .i_a(a_val), .i_b(b_val),
      .i_imm(x_q.ctl.imm), .i_br_nzp(x_q.ctl.br_nzp), .i_nzp(nzp_q),
      .o_result(alu_result), .o_br_taken(br_taken));

   assign m_in = '{ctl: x_q.ctl, result: alu_result, st_data: b_val};
   lc4_stage_reg #(.payload_t(m_stage_t)) u_m_reg (.gwe(gwe), .i_rst_n(i_rst_n),
      .i_hold(1'b0), .i_clear(1'b0), .i_d(m_in), .o_q(m_q));

   // Memory stage
   assign o_dmem_we      = m_q.ctl.is_store;
   assign o_dmem_addr    = (m_q.ctl.is_load || m_q.ctl.is_store) ? m_q.result : '0;
   assign o_dmem_towrite = st_sel ? w_q.ld_data : m_q.st_data;   // WM bypass

   assign w_in = '{ctl: m_q.ctl, result: m_q.result, ld_data: i_dmem_data};
   lc4_stage_reg #(.payload_t(w_stage_t)) u_w_reg (.gwe(gwe), .i_rst_n(i_rst_n),
      .i_hold(1'b0), .i_clear(1'b0), .i_d(w_in), .o_q(w_q));

   // Writeback and condition codes
   assign wb_data = w_q.ctl.is_load ? w_q.ld_data : w_q.result;
   assign wb_nzp  = {wb_data[15], wb_data == 16'h0000, !wb_data[15] && (|wb_data)};

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n)           nzp_q <= '0;
      else if (w_q.ctl.nzp_we) nzp_q <= wb_nzp;
   end

   assign o_wb_we   = w_q.ctl.regfile_we;
   assign o_wb_sel  = w_q.ctl.rd;
   assign o_wb_data = wb_data;

endmodule

`default_nettype wire

/* design/lc4_pkg.sv */
// Shared types and encodings for the five-stage LC4 pipeline subset
// Every design module imports this, and so does the testbench reference model
// Stage payload structs clear to all zeros, which is a bubble with no enables
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;      // One data or address word
   typedef logic [2:0]  reg_sel_t;   // Register index R0..R7
   typedef logic [2:0]  nzp_t;       // Negative, zero, positive

   // Opcodes in insn[15:12]
   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // Sub-ops in insn[5:3], arith and logic groups overlap
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   // Execute operation, ALU_ADDR also serves ADD with imm5
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS, ALU_ADDR, ALU_BR
   } alu_op_t;

   // Operand source for the execute-stage bypass muxes
   typedef enum logic [1:0] {BYP_REG, BYP_M, BYP_W} byp_sel_t;

   typedef struct packed {
      reg_sel_t rs;
      reg_sel_t rt;           // Data register for STR
      reg_sel_t rd;
      logic     rs_re;
      logic     rt_re;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      alu_op_t  alu_op;
      nzp_t     br_nzp;       // Branch condition mask
      word_t    imm;          // Sign-extended immediate
   } ctl_t;

   typedef struct packed {
      word_t pc;
      word_t insn;            // Zero is BR with nzp 000, a NOP
   } d_stage_t;

   typedef struct packed {
      ctl_t  ctl;
      word_t pc;
      word_t rs_data;
      word_t rt_data;
   } x_stage_t;

   typedef struct packed {
      ctl_t  ctl;
      word_t result;          // ALU result or memory address
      word_t st_data;
   } m_stage_t;

   typedef struct packed {
      ctl_t  ctl;
      word_t result;
      word_t ld_data;
   } w_stage_t;

   localparam word_t PC_RESET = 16'h8200;  // Boot address

endpackage

`default_nettype wire

/* design/lc4_regfile.sv */
// Eight-entry 16-bit register file, two read ports and one write port
// A read of the register being written returns the write data in the same cycle
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
   input  wire                    gwe,
   input  wire                    i_rst_n,
   input  wire lc4_pkg::reg_sel_t i_rs,
   input  wire lc4_pkg::reg_sel_t i_rt,
   input  wire lc4_pkg::reg_sel_t i_rd,
   input  wire                    i_we,
   input  wire lc4_pkg::word_t    i_wdata,
   output lc4_pkg::word_t         o_rs_data,
   output lc4_pkg::word_t         o_rt_data
);
   import lc4_pkg::*;

   word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) regs[i] <= '0;
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Writeback value forwarded straight into decode
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

/* design/lc4_stage_reg.sv */
// Pipeline latch for any stage payload
// Clear gives a bubble and beats hold, hold keeps the current contents
`timescale 1ns/1ps
`default_nettype none

module lc4_stage_reg #(
   parameter type payload_t = logic [15:0]
) (
   input  wire           gwe,
   input  wire           i_rst_n,
   input  wire           i_hold,     // Stall
   input  wire           i_clear,    // Flush or bubble insert
   input  wire payload_t i_d,
   output payload_t      o_q
);

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n)      o_q <= '0;   // All-zero payload is a NOP
      else if (i_clear)  o_q <= '0;
      else if (!i_hold)  o_q <= i_d;
   end

endmodule

`default_nettype wire

/* files.f */
design/lc4_pkg.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_alu.sv
design/lc4_hazard_ctrl.sv
design/lc4_stage_reg.sv
design/lc4_pipeline.sv
verif/tb_clk_gen.sv
verif/tb_lc4_pipeline.sv

/* run.sh */
#!/bin/sh
# Build the LC4 pipeline testbench with Verilator, run it and search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_lc4_pipeline -f files.f -o tb_sim \
   > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

/* verif/tb_clk_gen.sv */
// Clock and reset source for the LC4 pipeline testbench
// gwe runs with a 10 ns period, reset stays low for the first 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic gwe,
   output logic o_rst_n
);

   initial begin
      gwe = 1'b0;
      forever #5 gwe = ~gwe;               // 10 ns period
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (8) @(posedge gwe);
      #1 o_rst_n = 1'b1;                   // Released just after the edge
   end

endmodule

`default_nettype wire

/* verif/tb_lc4_pipeline.sv */
// Testbench for the LC4 pipeline top level
// Runs directed ALU, load/store and branch code, then a seeded random block
// An ISA model predicts every register write and store, checked in retire order
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_pipeline;
   import lc4_pkg::*;

   logic        gwe, rst_n, dmem_we, wb_we;
   word_t       cur_pc, cur_insn, dmem_addr, dmem_data, dmem_towrite, wb_data;
   reg_sel_t    wb_sel;
   word_t       imem [65536];
   word_t       dmem [65536];      // Seen by the DUT
   word_t       ref_mem [65536];   // Private copy of the model
   logic [18:0] exp_reg [$];       // {rd, value} in program order
   logic [31:0] exp_st [$];        // {addr, value}
   logic [18:0] exp_w;
   logic [31:0] exp_s;
   int          prog_len, cycles;
   integer      seed;

   tb_clk_gen u_clk (.gwe(gwe), .o_rst_n(rst_n));

   lc4_pipeline DUT (.gwe(gwe), .i_rst_n(rst_n), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
      .o_dmem_addr(dmem_addr), .i_dmem_data(dmem_data), .o_dmem_we(dmem_we),
      .o_dmem_towrite(dmem_towrite), .o_wb_we(wb_we), .o_wb_sel(wb_sel), .o_wb_data(wb_data));

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         fail_run($sformatf("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
   endtask

   // Memory contents before any store, every address bit matters
   function automatic word_t fill_word(input word_t a);
      return (a * 16'h9e37) ^ {a[7:0], a[15:8]};
   endfunction

   task automatic append_insn(input word_t insn);
      imem[PC_RESET + prog_len] = insn;
      prog_len++;
   endtask

   // Preload R0..R6, base R7 on the window 0x40..0x4F, then 40 random instructions
   task automatic build_random_block();
      logic [31:0] v;
      logic [3:0]  kind;
      reg_sel_t    rd;
      for (int r = 0; r < 7; r++) begin
         v = $random(seed);
         append_insn({OP_CONST, 3'(r), v[8:0]});
      end
      append_insn({OP_CONST, 3'd7, 9'h040});
      for (int k = 0; k < 40; k++) begin
         v    = $random(seed);
         kind = v[3:0] % 4'd10;
         rd   = (v[6:4] == 3'd7) ? 3'd0 : v[6:4];            // R7 never overwritten
         case (kind)
            4'd0: append_insn({OP_ARITH, rd, v[9:7], 3'b000, v[12:10]});
            4'd1: append_insn({OP_ARITH, rd, v[9:7], 3'b010, v[12:10]});
            4'd2: append_insn({OP_ARITH, rd, v[9:7], 1'b1, v[28:24]});
            4'd3: append_insn({OP_LOGIC, rd, v[9:7], 3'b000, v[12:10]});
            4'd4: append_insn({OP_LOGIC, rd, v[9:7], 3'b010, v[12:10]});
            4'd5: append_insn({OP_LOGIC, rd, v[9:7], 3'b011, v[12:10]});
            4'd6: append_insn({OP_CONST, rd, v[31:23]});
            4'd7: append_insn({OP_LDR, rd, 3'd7, 2'b00, v[15:12]});
            4'd8: append_insn({OP_STR, v[18:16], 3'd7, 2'b00, v[15:12]});
            default: append_insn({OP_BR, v[21:19], 7'd0, v[23:22]});   // Forward only
         endcase
      end
   endtask

   // Sequential ISA model, one instruction at a time from PC_RESET
   function automatic void lc4_ref_run();
      word_t regs [8];
      word_t pc, insn, rs_v, rt_v, addr, val;
      nzp_t  nzp;
      logic  wr;
      for (int i = 0; i < 8; i++)
         regs[i] = '0;
      pc  = PC_RESET;
      nzp = '0;                                               // No branch taken before a write
      while (pc >= PC_RESET && pc < PC_RESET + prog_len) begin
         insn = imem[pc];
         pc   = pc + 16'd1;
         rs_v = regs[insn[8:6]];
         rt_v = regs[insn[2:0]];
         addr = rs_v + {{10{insn[5]}}, insn[5:0]};
         wr   = 1'b1;
         casez (insn)
            16'b0001_???_???_1?????: val = rs_v + {{11{insn[4]}}, insn[4:0]};
            16'b0001_???_???_000???: val = rs_v + rt_v;
            16'b0001_???_???_010???: val = rs_v - rt_v;
            16'b0101_???_???_000???: val = rs_v & rt_v;
            16'b0101_???_???_010???: val = rs_v | rt_v;
            16'b0101_???_???_011???: val = rs_v ^ rt_v;
            16'b1001_???_?????????:  val = {{7{insn[8]}}, insn[8:0]};
            16'b0110_???_???_??????: val = ref_mem[addr];
            16'b0111_???_???_??????: begin
               wr = 1'b0;
               ref_mem[addr] = regs[insn[11:9]];
               exp_st.push_back({addr, regs[insn[11:9]]});
            end
            16'b0000_???_?????????: begin
               wr = 1'b0;
               if ((insn[11:9] & nzp) != 3'b000)
                  pc = pc + {{7{insn[8]}}, insn[8:0]};
            end
            default: wr = 1'b0;                               // Outside the subset
         endcase
         if (wr) begin
            regs[insn[11:9]] = val;
            nzp = val[15] ? 3'b100 : (val == 16'h0000) ? 3'b010 : 3'b001;
            exp_reg.push_back({insn[11:9], val});
         end
      end
   endfunction

   // Memory read data, 1 ns after each rising edge
   always @(posedge gwe) begin
      #1;
      cur_insn  = imem[cur_pc];
      dmem_data = dmem[dmem_addr];
   end

   always @(posedge gwe) begin
      if (rst_n) begin
         cycles = cycles + 1;
         if (cycles > prog_len * 4 + 50)
            fail_run("Timeout: the pipeline did not retire all expected writes");
      end
   end

   // Compare on the falling edge, outputs settled
   always @(negedge gwe) begin
      if (!rst_n) begin
         check_value("o_cur_pc", cur_pc, PC_RESET);
         check_value("o_wb_we", {15'd0, wb_we}, 16'h0000);
         check_value("o_dmem_we", {15'd0, dmem_we}, 16'h0000);
      end else begin
         if (wb_we) begin
            if (exp_reg.size() == 0)
               fail_run("A register write retired after the last expected one");
            else begin
               exp_w = exp_reg.pop_front();
               check_value("o_wb_sel", {13'd0, wb_sel}, {13'd0, exp_w[18:16]});
               check_value("o_wb_data", wb_data, exp_w[15:0]);
            end
         end
         if (dmem_we) begin
            if (exp_st.size() == 0)
               fail_run("A store happened after the last expected one");
            else begin
               exp_s = exp_st.pop_front();
               check_value("o_dmem_addr", dmem_addr, exp_s[31:16]);
               check_value("o_dmem_towrite", dmem_towrite, exp_s[15:0]);
               dmem[dmem_addr] = dmem_towrite;
            end
         end
      end
   end

   initial begin
      cur_insn  = '0;
      dmem_data = '0;
      seed      = 32'h325739f1;
      prog_len  = 0;
      cycles    = 0;
      for (int a = 0; a < 65536; a++) begin
         imem[a]    = '0;                                    // BR nzp 000
         dmem[a]    = fill_word(word_t'(a));
         ref_mem[a] = fill_word(word_t'(a));
      end
      append_insn({OP_CONST, 3'd1, 9'h005});                 // R1 = 5
      append_insn({OP_CONST, 3'd2, 9'h1fd});                 // R2 = -3
      append_insn({OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd2});     // ADD, MX on R2 and WX on R1
      append_insn({OP_ARITH, 3'd4, 3'd3, 3'b010, 3'd1});     // SUB
      append_insn({OP_ARITH, 3'd5, 3'd4, 1'b1, 5'h19});      // ADD imm -7
      append_insn({OP_LOGIC, 3'd6, 3'd5, 3'b000, 3'd2});     // AND
      append_insn({OP_LOGIC, 3'd0, 3'd6, 3'b010, 3'd4});     // OR
      append_insn({OP_LOGIC, 3'd1, 3'd0, 3'b011, 3'd5});     // XOR
      append_insn({OP_CONST, 3'd7, 9'h040});
      append_insn({OP_LDR, 3'd2, 3'd7, 6'd3});
      append_insn({OP_ARITH, 3'd3, 3'd2, 3'b000, 3'd2});     // Load-use stall
      append_insn({OP_LDR, 3'd4, 3'd7, 6'd5});
      append_insn({OP_STR, 3'd4, 3'd7, 6'd9});               // WM bypass of R4
      append_insn({OP_LDR, 3'd5, 3'd7, 6'd9});               // Reads the stored word back
      append_insn({OP_CONST, 3'd6, 9'h000});                 // Sets Z
      append_insn({OP_BR, 3'b010, 9'd2});                    // BRz taken right behind the writer
      append_insn({OP_CONST, 3'd1, 9'h055});                 // Squashed
      append_insn({OP_STR, 3'd1, 3'd7, 6'd1});               // Squashed
      append_insn({OP_CONST, 3'd2, 9'h001});                 // Branch target, sets P
      append_insn({OP_BR, 3'b100, 9'd1});                    // BRn not taken
      append_insn({OP_ARITH, 3'd3, 3'd2, 3'b000, 3'd2});
      build_random_block();
      lc4_ref_run();
      @(posedge rst_n);
      while (exp_reg.size() != 0 || exp_st.size() != 0)
         @(posedge gwe);
      repeat (10) @(posedge gwe);                            // Room for stray writes to show
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire
